//--- trans_fifo_pkg.sv
package trans_fifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Transfer word field widths
	////////////////////////////////////////////////////////////////////////////

	// Metadata field, layer and tile tags from the host
	localparam int TRANS_IN_META_WIDTH = 16;

	// Payload field, one beat of feature data
	localparam int TRANS_IN_PYLD_WIDTH = 64;

	////////////////////////////////////////////////////////////////////////////
	// FIFO geometry
	////////////////////////////////////////////////////////////////////////////

	// Entries per FIFO, must stay a power of two
	localparam int TRANS_IN_FIFO_DEPTH = 16;

	// Memory address bits
	localparam int TRANS_IN_ADDR_WIDTH = $clog2(TRANS_IN_FIFO_DEPTH);

	// Fill level counts 0 to depth inclusive
	// Also the pointer width, address plus one wrap bit
	localparam int TRANS_IN_LEVEL_WIDTH = TRANS_IN_ADDR_WIDTH + 1;

	////////////////////////////////////////////////////////////////////////////
	// Transfer word
	////////////////////////////////////////////////////////////////////////////

	// Metadata sits in the upper bits, payload in the lower bits
	// Both halves are written and read as one entry
	typedef struct packed {
		logic [TRANS_IN_META_WIDTH-1:0] meta;
		logic [TRANS_IN_PYLD_WIDTH-1:0] pyld;
	} trans_in_word_t;

endpackage

//--- trans_cfg_pkg.sv
package trans_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////

	localparam int TRANS_CFG_ADDR_WIDTH = 2;
	localparam int TRANS_CFG_DATA_WIDTH = 8;

	// Almost-full threshold, read and write
	localparam logic [TRANS_CFG_ADDR_WIDTH-1:0] TRANS_CFG_ADDR_THRESH = 2'd0;
	// Status, write 1 to clear
	localparam logic [TRANS_CFG_ADDR_WIDTH-1:0] TRANS_CFG_ADDR_STATUS = 2'd1;
	// Write-side fill level, read only
	localparam logic [TRANS_CFG_ADDR_WIDTH-1:0] TRANS_CFG_ADDR_LEVEL  = 2'd2;

	// Sticky overflow position in STATUS
	localparam int TRANS_CFG_STATUS_OVF_BIT = 0;

	// One-cycle strobes, never both high
	typedef struct packed {
		logic                            wr;
		logic                            rd;
		logic [TRANS_CFG_ADDR_WIDTH-1:0] addr;
		logic [TRANS_CFG_DATA_WIDTH-1:0] wdata;
	} trans_cfg_req_t;

	////////////////////////////////////////////////////////////////////////////
	// Reset sequencing
	////////////////////////////////////////////////////////////////////////////

	// Busy hold after reset release, in domain clocks
	localparam int TRANS_RST_BUSY_CYCLES = 4;
	localparam int TRANS_RST_CNT_WIDTH   = $clog2(TRANS_RST_BUSY_CYCLES + 1);

endpackage

//--- trans_rst_sync.sv
`timescale 1ns/1ps

module trans_rst_sync #(
	// Set when reset comes from another clock domain
	parameter bit SYNC_EN = 1'b1
) (
	input  logic clk,
	input  logic reset,
	output logic domain_reset,
	output logic busy
);
	import trans_cfg_pkg::*;

	// Reset as seen in this domain
	logic reset_dom;
	// Cycles of busy left after release
	logic [TRANS_RST_CNT_WIDTH-1:0] busy_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Reset capture
	////////////////////////////////////////////////////////////////////////////

	generate
		if (SYNC_EN) begin : g_sync
			// Two-flop synchronizer
			// Meta flop first, stable flop second
			logic [1:0] sync_q;

			always_ff @(posedge clk) begin
				sync_q <= {sync_q[0], reset};
			end

			assign reset_dom = sync_q[1];
		end else begin : g_direct
			// Already synchronous to clk
			assign reset_dom = reset;
		end
	endgenerate

	assign domain_reset = reset_dom;

	////////////////////////////////////////////////////////////////////////////
	// Busy hold counter
	////////////////////////////////////////////////////////////////////////////

	// Loaded while reset is high, counts down to zero after release
	always_ff @(posedge clk) begin
		if (reset_dom) begin
			busy_cnt <= TRANS_RST_CNT_WIDTH'(TRANS_RST_BUSY_CYCLES);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign busy = (busy_cnt != '0);

endmodule

//--- trans_async_fifo.sv
`timescale 1ns/1ps

module trans_async_fifo #(
	parameter int WIDTH = 64
) (
	input  logic                                           wr_clk,
	input  logic                                           rd_clk,
	input  logic                                           wr_reset,
	input  logic                                           rd_reset,
	input  logic                                           wr_busy,
	input  logic                                           rd_busy,
	input  logic [WIDTH-1:0]                               din,
	input  logic                                           wr_en,
	input  logic                                           rd_en,
	output logic [WIDTH-1:0]                               dout,
	output logic                                           full,
	output logic                                           empty,
	output logic                                           valid,
	output logic [trans_fifo_pkg::TRANS_IN_LEVEL_WIDTH-1:0] wr_level,
	output logic                                           wr_drop
);
	import trans_fifo_pkg::*;

	// Storage, no reset
	logic [WIDTH-1:0] mem [TRANS_IN_FIFO_DEPTH];

	// Write domain pointers
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_bin;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_bin_next;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_gray;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_gray_next;
	// Read gray pointer brought into wr_clk
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_gray_meta;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_gray_sync;
	logic                            wr_accept;

	// Read domain pointers
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_bin;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_bin_next;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_gray;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] rd_gray_next;
	// Write gray pointer brought into rd_clk
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_gray_meta;
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_gray_sync;
	logic                            rd_accept;

	// Gray back to binary, MSB first
	function automatic logic [TRANS_IN_LEVEL_WIDTH-1:0] gray2bin(
		input logic [TRANS_IN_LEVEL_WIDTH-1:0] g
	);
		logic [TRANS_IN_LEVEL_WIDTH-1:0] b;
		b[TRANS_IN_LEVEL_WIDTH-1] = g[TRANS_IN_LEVEL_WIDTH-1];
		for (int i = TRANS_IN_LEVEL_WIDTH - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	// Refused while full or still coming out of reset
	assign wr_accept    = wr_en & ~full & ~wr_busy;
	assign wr_bin_next  = wr_bin + TRANS_IN_LEVEL_WIDTH'(wr_accept);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	always_ff @(posedge wr_clk) begin
		if (wr_accept) begin
			mem[wr_bin[TRANS_IN_ADDR_WIDTH-1:0]] <= din;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_bin       <= '0;
			wr_gray      <= '0;
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
			full         <= 1'b0;
			wr_level     <= '0;
			wr_drop      <= 1'b0;
		end else begin
			wr_bin       <= wr_bin_next;
			wr_gray      <= wr_gray_next;
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
			// Full when next write pointer laps the read pointer
			// Gray form flips the top two bits
			full <= (wr_gray_next == {~rd_gray_sync[TRANS_IN_LEVEL_WIDTH-1 -: 2],
				rd_gray_sync[TRANS_IN_LEVEL_WIDTH-3:0]});
			// Pessimistic level, read side frees space late
			wr_level <= wr_bin_next - gray2bin(rd_gray_sync);
			// One pulse per refused write
			wr_drop  <= wr_en & ~wr_accept;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	assign rd_accept    = rd_en & ~empty & ~rd_busy;
	assign rd_bin_next  = rd_bin + TRANS_IN_LEVEL_WIDTH'(rd_accept);
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	// Data register, no reset
	always_ff @(posedge rd_clk) begin
		if (rd_accept) begin
			dout <= mem[rd_bin[TRANS_IN_ADDR_WIDTH-1:0]];
		end
	end

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_bin       <= '0;
			rd_gray      <= '0;
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
			empty        <= 1'b1;
			valid        <= 1'b0;
		end else begin
			rd_bin       <= rd_bin_next;
			rd_gray      <= rd_gray_next;
			wr_gray_meta <= wr_gray;
			wr_gray_sync <= wr_gray_meta;
			// Empty when pointers meet, exact match in gray
			empty        <= (rd_gray_next == wr_gray_sync);
			// Single cycle strobe beside dout
			valid        <= rd_accept;
		end
	end

endmodule

//--- cnn_layer_accel_trans_in_fifo.sv
`timescale 1ns/1ps

module cnn_layer_accel_trans_in_fifo (
	input  logic                                           reset,
	input  logic                                           wr_clk,
	input  logic                                           rd_clk,
	input  trans_fifo_pkg::trans_in_word_t                 din,
	input  logic                                           wr_en,
	input  logic                                           rd_en,
	output trans_fifo_pkg::trans_in_word_t                 dout,
	output logic                                           full,
	output logic                                           empty,
	output logic                                           valid,
	output logic                                           wr_rst_busy,
	output logic                                           rd_rst_busy,
	output logic [trans_fifo_pkg::TRANS_IN_LEVEL_WIDTH-1:0] wr_level,
	output logic                                           wr_drop
);
	import trans_fifo_pkg::*;

	// Domain resets
	logic wr_reset;
	logic rd_reset;

	// Metadata FIFO
	logic [TRANS_IN_META_WIDTH-1:0] meta_dout;
	logic                           meta_full;
	logic                           meta_empty;
	logic                           meta_valid;

	// Payload FIFO
	logic [TRANS_IN_PYLD_WIDTH-1:0] pyld_dout;
	logic                           pyld_full;
	logic                           pyld_empty;
	logic                           pyld_valid;

	////////////////////////////////////////////////////////////////////////////
	// Reset per domain
	////////////////////////////////////////////////////////////////////////////

	// Write side reset is already on wr_clk
	trans_rst_sync #(.SYNC_EN(1'b0)) i0_trans_in_wr_rst_sync (
		.clk(wr_clk), .reset(reset), .domain_reset(wr_reset), .busy(wr_rst_busy)
	);

	// Read side crosses in through two flops
	trans_rst_sync #(.SYNC_EN(1'b1)) i0_trans_in_rd_rst_sync (
		.clk(rd_clk), .reset(reset), .domain_reset(rd_reset), .busy(rd_rst_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Field FIFOs
	////////////////////////////////////////////////////////////////////////////

	// Level and drop taken from payload side only
	trans_async_fifo #(.WIDTH(TRANS_IN_META_WIDTH)) i0_trans_in_meta_fifo (
		.wr_clk(wr_clk), .rd_clk(rd_clk), .wr_reset(wr_reset), .rd_reset(rd_reset),
		.wr_busy(wr_rst_busy), .rd_busy(rd_rst_busy), .din(din.meta),
		.wr_en(wr_en), .rd_en(rd_en), .dout(meta_dout), .full(meta_full),
		.empty(meta_empty), .valid(meta_valid), .wr_level(), .wr_drop()
	);

	trans_async_fifo #(.WIDTH(TRANS_IN_PYLD_WIDTH)) i0_trans_in_pyld_fifo (
		.wr_clk(wr_clk), .rd_clk(rd_clk), .wr_reset(wr_reset), .rd_reset(rd_reset),
		.wr_busy(wr_rst_busy), .rd_busy(rd_rst_busy), .din(din.pyld),
		.wr_en(wr_en), .rd_en(rd_en), .dout(pyld_dout), .full(pyld_full),
		.empty(pyld_empty), .valid(pyld_valid), .wr_level(wr_level), .wr_drop(wr_drop)
	);

	// Rejoin fields, meta on top
	assign dout  = '{meta: meta_dout, pyld: pyld_dout};

	// Either side blocks, both must deliver
	assign full  = meta_full | pyld_full;
	assign empty = meta_empty | pyld_empty;
	assign valid = meta_valid & pyld_valid;

endmodule

//--- trans_in_cfg_regs.sv
`timescale 1ns/1ps

module trans_in_cfg_regs (
	input  logic                                            wr_clk,
	input  logic                                            reset,
	input  trans_cfg_pkg::trans_cfg_req_t                   cfg,
	input  logic [trans_fifo_pkg::TRANS_IN_LEVEL_WIDTH-1:0]  wr_level,
	input  logic                                            wr_drop,
	output logic [trans_cfg_pkg::TRANS_CFG_DATA_WIDTH-1:0]   cfg_rdata,
	output logic                                            prog_full
);
	import trans_fifo_pkg::*;
	import trans_cfg_pkg::*;

	// Almost-full threshold in entries
	logic [TRANS_CFG_DATA_WIDTH-1:0] thresh;
	// Sticky overflow
	logic                            ovf;
	// Decoded write strobes
	logic                            thresh_we;
	logic                            ovf_clr;

	assign thresh_we = cfg.wr && (cfg.addr == TRANS_CFG_ADDR_THRESH);
	assign ovf_clr   = cfg.wr && (cfg.addr == TRANS_CFG_ADDR_STATUS)
		&& cfg.wdata[TRANS_CFG_STATUS_OVF_BIT];

	////////////////////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge wr_clk) begin
		if (reset) begin
			// Default threshold equals depth, so same as full
			thresh    <= TRANS_CFG_DATA_WIDTH'(TRANS_IN_FIFO_DEPTH);
			ovf       <= 1'b0;
			prog_full <= 1'b0;
		end else begin
			if (thresh_we) begin
				thresh <= cfg.wdata;
			end
			// New drop beats a clear in the same cycle
			if (wr_drop) begin
				ovf <= 1'b1;
			end else if (ovf_clr) begin
				ovf <= 1'b0;
			end
			prog_full <= (TRANS_CFG_DATA_WIDTH'(wr_level) >= thresh);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	// Holds last read value between strobes
	always_ff @(posedge wr_clk) begin
		if (reset) begin
			cfg_rdata <= '0;
		end else if (cfg.rd) begin
			case (cfg.addr)
				TRANS_CFG_ADDR_THRESH: cfg_rdata <= thresh;
				TRANS_CFG_ADDR_STATUS: cfg_rdata <= TRANS_CFG_DATA_WIDTH'(ovf);
				TRANS_CFG_ADDR_LEVEL:  cfg_rdata <= TRANS_CFG_DATA_WIDTH'(wr_level);
				default:               cfg_rdata <= '0;
			endcase
		end
	end

endmodule

//--- trans_in_top.sv
`timescale 1ns/1ps

module trans_in_top (
	// Write domain
	input  logic                                          wr_clk,
	input  logic                                          reset,
	input  logic                                          wr_en,
	input  trans_fifo_pkg::trans_in_word_t                din,
	output logic                                          full,
	output logic                                          wr_rst_busy,
	input  trans_cfg_pkg::trans_cfg_req_t                 cfg,
	output logic [trans_cfg_pkg::TRANS_CFG_DATA_WIDTH-1:0] cfg_rdata,
	output logic                                          prog_full,
	// Read domain
	input  logic                                          rd_clk,
	input  logic                                          rd_en,
	output trans_fifo_pkg::trans_in_word_t                dout,
	output logic                                          valid,
	output logic                                          empty,
	output logic                                          rd_rst_busy
);
	import trans_fifo_pkg::*;

	// FIFO status into the register block
	logic [TRANS_IN_LEVEL_WIDTH-1:0] wr_level;
	logic                            wr_drop;

	////////////////////////////////////////////////////////////////////////////
	// Transfer FIFO pair
	////////////////////////////////////////////////////////////////////////////

	cnn_layer_accel_trans_in_fifo i0_cnn_layer_accel_trans_in_fifo (
		.reset(reset), .wr_clk(wr_clk), .rd_clk(rd_clk), .din(din),
		.wr_en(wr_en), .rd_en(rd_en), .dout(dout), .full(full),
		.empty(empty), .valid(valid), .wr_rst_busy(wr_rst_busy),
		.rd_rst_busy(rd_rst_busy), .wr_level(wr_level), .wr_drop(wr_drop)
	);

	// Write domain config and status
	trans_in_cfg_regs i0_trans_in_cfg_regs (
		.wr_clk(wr_clk), .reset(reset), .cfg(cfg), .wr_level(wr_level),
		.wr_drop(wr_drop), .cfg_rdata(cfg_rdata), .prog_full(prog_full)
	);

endmodule

//--- trans_in_sva.sv
`timescale 1ns/1ps

module trans_in_sva (
	input logic reset,
	input logic wr_clk,
	input logic rd_clk,
	input logic rd_en,
	input logic full,
	input logic empty,
	input logic valid,
	input logic wr_rst_busy,
	input logic rd_rst_busy,
	input logic wr_drop
);
	// Failure counts per clock domain, read by the testbench
	int wr_fail_count = 0;
	int rd_fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Write domain
	////////////////////////////////////////////////////////////////////////////

	// Merged flags never claim full and empty at once
	flags_exclusive: assert property (@(posedge wr_clk) disable iff (reset)
		!(full && empty))
		else begin wr_fail_count++; $error("full and empty both high"); end

	// Nothing accepted or refused while coming out of reset
	wr_busy_quiet: assert property (@(posedge wr_clk) disable iff (reset)
		wr_rst_busy |-> (!full && !wr_drop))
		else begin wr_fail_count++; $error("full or wr_drop high while busy"); end

	////////////////////////////////////////////////////////////////////////////
	// Read domain
	////////////////////////////////////////////////////////////////////////////

	// Each valid needs an accepted read one cycle earlier
	valid_after_read: assert property (@(posedge rd_clk) disable iff (reset)
		valid |-> $past(rd_en && !empty && !rd_rst_busy))
		else begin rd_fail_count++; $error("valid without an accepted read"); end

	// No data out during the busy window
	rd_busy_quiet: assert property (@(posedge rd_clk) disable iff (reset)
		rd_rst_busy |-> !valid)
		else begin rd_fail_count++; $error("valid high while read side busy"); end

endmodule

bind cnn_layer_accel_trans_in_fifo trans_in_sva sva_i (
	.reset(reset), .wr_clk(wr_clk), .rd_clk(rd_clk), .rd_en(rd_en), .full(full),
	.empty(empty), .valid(valid), .wr_rst_busy(wr_rst_busy),
	.rd_rst_busy(rd_rst_busy), .wr_drop(wr_drop)
);

//--- trans_in_tb.sv
`timescale 1ns/1ps

module trans_in_tb;
	import trans_fifo_pkg::*;
	import trans_cfg_pkg::*;

	localparam int WATCHDOG_CYCLES = 8 * TRANS_IN_FIFO_DEPTH + 400;

	logic wr_clk = 1'b0;
	logic rd_clk = 1'b0;
	logic rd_started = 1'b0;
	logic reset = 1'b1;
	logic wr_en = 1'b0;
	logic rd_en = 1'b0;
	trans_in_word_t din = '0;
	trans_cfg_req_t cfg = '0;
	trans_in_word_t dout;
	logic full;
	logic empty;
	logic valid;
	logic prog_full;
	logic wr_rst_busy;
	logic rd_rst_busy;
	logic [TRANS_CFG_DATA_WIDTH-1:0] cfg_rdata;

	// Shared random source, stepped per bit
	logic [15:0] lfsr = 16'd40669;
	logic [79:0] rd_bits;
	// Reader behavior, 0 idle, 1 random strobes, 2 read every cycle
	int rd_mode = 0;
	// Accepted writes still to come out of dout
	trans_in_word_t ref_q[$];
	trans_in_word_t expected;
	int accepted = 0;

	trans_in_top dut_i (
		.wr_clk(wr_clk), .reset(reset), .wr_en(wr_en), .din(din), .full(full),
		.wr_rst_busy(wr_rst_busy), .cfg(cfg), .cfg_rdata(cfg_rdata),
		.prog_full(prog_full), .rd_clk(rd_clk), .rd_en(rd_en), .dout(dout),
		.valid(valid), .empty(empty), .rd_rst_busy(rd_rst_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Clocks, read side 7 ns behind
	////////////////////////////////////////////////////////////////////////////

	always #20 wr_clk = ~wr_clk;

	always begin
		if (!rd_started) begin
			rd_started = 1'b1;
			#7;
		end
		#20 rd_clk = ~rd_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [79:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[78:0], lfsr[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [79:0] exp,
		input logic [79:0] act);
		$display("Fail %s: expected %0h, actual %0h", name, exp, act);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("Error: %s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic int sva_failures();
		return dut_i.i0_cnn_layer_accel_trans_in_fifo.sva_i.wr_fail_count
			+ dut_i.i0_cnn_layer_accel_trans_in_fifo.sva_i.rd_fail_count;
	endfunction

	// Called on a falling edge, returns on the next one
	task automatic drive_write(input logic en, input trans_in_word_t w);
		wr_en = en;
		din = w;
		// Accept rule, full and busy as the next rising edge sees them
		if (en && !full && !wr_rst_busy) begin
			ref_q.push_back(w);
			accepted++;
		end
		@(negedge wr_clk);
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
		cfg = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(negedge wr_clk);
		cfg = '0;
	endtask

	task automatic cfg_read(input logic [1:0] addr, output logic [7:0] data);
		cfg = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 8'h00};
		@(negedge wr_clk);
		cfg = '0;
		data = cfg_rdata;
	endtask

	// Read until every accepted word came out, then let pointers settle
	task automatic wait_drain();
		rd_mode = 2;
		while (ref_q.size() != 0) begin
			@(negedge wr_clk);
		end
		rd_mode = 0;
		repeat (4) @(negedge wr_clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Read driver and output checker
	////////////////////////////////////////////////////////////////////////////

	always @(negedge rd_clk) begin
		if (rd_mode == 1) begin
			take_bits(1, rd_bits);
			rd_en = rd_bits[0];
		end else begin
			rd_en = (rd_mode == 2);
		end
	end

	always @(negedge rd_clk) begin
		if (valid) begin
			assert (ref_q.size() != 0)
				else report_problem("valid came with no accepted word left to read");
			expected = ref_q.pop_front();
			assert (dout == expected) else report_mismatch("dout", expected, dout);
		end
	end

	always @(negedge wr_clk) begin
		assert (sva_failures() == 0)
			else report_problem("a concurrent assertion on the FIFO wrapper failed");
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge wr_clk);
		report_problem("watchdog expired before the tests finished");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		trans_in_word_t w;
		logic [79:0] bits;
		logic [7:0] rdata;
		logic [7:0] thresh_val;

		// Reset, busy flags and reset values
		repeat (8) @(negedge wr_clk);
		assert (wr_rst_busy && rd_rst_busy)
			else report_problem("busy flags did not rise during reset");
		reset = 1'b0;
		cfg_read(TRANS_CFG_ADDR_THRESH, rdata);
		assert (rdata == 8'(TRANS_IN_FIFO_DEPTH))
			else report_mismatch("cfg_rdata", TRANS_IN_FIFO_DEPTH, rdata);
		while (wr_rst_busy || rd_rst_busy) begin
			assert (empty && !full && !valid && !prog_full)
				else report_problem("flags left their reset values while busy");
			@(negedge wr_clk);
		end

		// Random writes against random reads, writer watches full
		rd_mode = 1;
		for (int i = 0; i < 48; i++) begin
			take_bits(1, bits);
			take_bits(80, w);
			drive_write(bits[0] && !full, w);
		end
		drive_write(1'b0, '0);
		wait_drain();

		// Fill without reads, then one dropped write
		accepted = 0;
		for (int i = 0; i < TRANS_IN_FIFO_DEPTH; i++) begin
			assert (!full) else report_problem("full rose before the FIFO was filled");
			take_bits(80, w);
			drive_write(1'b1, w);
		end
		assert (full) else report_mismatch("full", 1, full);
		take_bits(80, w);
		drive_write(1'b1, w);
		drive_write(1'b0, '0);
		cfg_read(TRANS_CFG_ADDR_STATUS, rdata);
		assert (rdata == 8'h01) else report_mismatch("cfg_rdata", 1, rdata);
		cfg_read(TRANS_CFG_ADDR_LEVEL, rdata);
		assert (rdata == 8'(accepted)) else report_mismatch("cfg_rdata", accepted, rdata);
		cfg_write(TRANS_CFG_ADDR_STATUS, 8'h01);
		cfg_read(TRANS_CFG_ADDR_STATUS, rdata);
		assert (rdata == 8'h00) else report_mismatch("cfg_rdata", 0, rdata);
		wait_drain();

		// Programmable threshold between 4 and 11
		take_bits(3, bits);
		thresh_val = 8'(bits[2:0]) + 8'd4;
		cfg_write(TRANS_CFG_ADDR_THRESH, thresh_val);
		accepted = 0;
		for (int i = 0; i < thresh_val - 1; i++) begin
			take_bits(80, w);
			drive_write(1'b1, w);
		end
		drive_write(1'b0, '0);
		drive_write(1'b0, '0);
		assert (!prog_full) else report_mismatch("prog_full", 0, prog_full);
		cfg_read(TRANS_CFG_ADDR_LEVEL, rdata);
		assert (rdata == 8'(accepted)) else report_mismatch("cfg_rdata", accepted, rdata);
		take_bits(80, w);
		drive_write(1'b1, w);
		drive_write(1'b0, '0);
		drive_write(1'b0, '0);
		assert (prog_full) else report_mismatch("prog_full", 1, prog_full);
		cfg_read(TRANS_CFG_ADDR_LEVEL, rdata);
		assert (rdata == 8'(accepted)) else report_mismatch("cfg_rdata", accepted, rdata);
		wait_drain();

		// Reads on an empty FIFO consume nothing
		rd_mode = 2;
		repeat (6) @(negedge wr_clk);
		rd_mode = 0;
		repeat (2) @(negedge wr_clk);
		take_bits(80, w);
		drive_write(1'b1, w);
		drive_write(1'b0, '0);
		wait_drain();

		if (sva_failures() == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
trans_fifo_pkg.sv
trans_cfg_pkg.sv
trans_rst_sync.sv
trans_async_fifo.sv
cnn_layer_accel_trans_in_fifo.sv
trans_in_cfg_regs.sv
trans_in_top.sv
trans_in_sva.sv
trans_in_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= trans_in_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
